// File: Bender.yml
package:
  name: soc_core

sources:
  - socPkg.sv
  - socAddressDecode.sv
  - ramBank.sv
  - timerBlock.sv
  - randomSource.sv
  - interruptController.sv
  - readReturn.sv
  - socCore.sv
  - target: test
    files:
      - socCoreTb.sv

// File: compile.f
socPkg.sv
socAddressDecode.sv
ramBank.sv
timerBlock.sv
randomSource.sv
interruptController.sv
readReturn.sv
socCore.sv
socCoreTb.sv

// File: interruptController.sv
`timescale 1ns/100ps

module interruptController import socPkg::*; (
    input   logic                   clk,
    input   logic                   rstN,
    input   periphReqT              req,
    input   logic [numTimers-1:0]   timerIrq,
    output  periphRspT              rsp,
    output  logic                   interruptRequest
);

    logic  [irqLines-1:0]   pending;
    logic  [irqLines-1:0]   mask;
    logic  [irqLines-1:0]   setBits;
    logic  [irqLines-1:0]   clearBits;
    logic  [31:0]           readData;
    logic                   readValid;

    // timers own the low lines, the rest stay idle
    always_comb begin
        setBits                = '0;
        setBits[numTimers-1:0] = timerIrq;
    end

    // write one to clear
    assign clearBits = (req.write && (req.offset == irqClearOffset)) ?
                       req.writeData[irqLines-1:0] : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pending          <= '0;
            mask             <= '0;
            interruptRequest <= 1'b0;
            readValid        <= 1'b0;
        end else begin
            // a new pulse beats a clear in the same cycle
            pending          <= (pending & ~clearBits) | setBits;
            interruptRequest <= |(pending & mask);
            readValid        <= req.read;
            if (req.write && (req.offset == irqMaskOffset)) begin
                mask <= req.writeData[irqLines-1:0];
            end
        end
    end

    // clear offset reads back pending
    always_ff @(posedge clk) begin
        if (req.read) begin
            case (req.offset)
                irqMaskOffset:  readData <= 32'(mask);
                irqClearOffset: readData <= 32'(pending);
                default:        readData <= '0;
            endcase
        end
    end

    assign rsp = '{valid: readValid, data: readData};

endmodule

// File: ramBank.sv
`timescale 1ns/100ps

module ramBank import socPkg::*; #(
    parameter int ramWords = 4096
) (
    input   logic           clk,
    input   logic           rstN,
    input   periphReqT      req,
    output  periphRspT      rsp
);

    // at least one index bit even for a single word
    localparam int addrBits = (ramWords > 1) ? $clog2(ramWords) : 1;

    logic  [31:0]           mem [ramWords];
    logic  [addrBits-1:0]   wordAddr;
    logic  [31:0]           readWord;
    logic                   readValid;

    // decoder already checked the range
    assign wordAddr = req.offset[addrBits-1:0];

    // byte lanes written separately
    always_ff @(posedge clk) begin
        if (req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.bwe[b]) begin
                    mem[wordAddr][8*b +: 8] <= req.writeData[8*b +: 8];
                end
            end
        end
        if (req.read) begin
            readWord <= mem[wordAddr];
        end
    end

    // response one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end

    assign rsp = '{valid: readValid, data: readWord};

endmodule

// File: randomSource.sv
`timescale 1ns/100ps

module randomSource import socPkg::*; (
    input   logic           clk,
    input   logic           rstN,
    input   periphReqT      req,
    output  periphRspT      rsp
);

    logic  [31:0]   state;
    logic  [31:0]   readData;
    logic           readValid;

    // one xorshift32 step, shifts 13 17 5
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= randomSeedDefault;
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
            if (req.read) begin
                state <= xorshift32(state);
            end else if (req.write) begin
                // zero would lock the generator
                state <= (req.writeData == '0) ? randomSeedDefault : req.writeData;
            end
        end
    end

    // value handed out is the state before the step
    always_ff @(posedge clk) begin
        if (req.read) begin
            readData <= state;
        end
    end

    assign rsp = '{valid: readValid, data: readData};

endmodule

// File: readReturn.sv
`timescale 1ns/100ps

module readReturn import socPkg::*; (
    input   logic           clk,
    input   logic           rstN,
    input   periphRspT      ramRsp,
    input   periphRspT      timerRsp,
    input   periphRspT      randomRsp,
    input   periphRspT      irqRsp,
    input   logic           badRead,
    output  logic           readValid,
    output  logic  [31:0]   readData
);

    periphRspT      rspList [4];
    logic           badReadDelay;
    logic           mergedValid;
    logic  [31:0]   mergedData;

    assign rspList = '{ramRsp, timerRsp, randomRsp, irqRsp};

    // align with the targets' one cycle response
    always_ff @(posedge clk) begin
        if (!rstN) begin
            badReadDelay <= 1'b0;
        end else begin
            badReadDelay <= badRead;
        end
    end

    // at most one source is valid, a bad read keeps zero data
    always_comb begin
        mergedValid = badReadDelay;
        mergedData  = '0;
        for (int i = 0; i < 4; i++) begin
            if (rspList[i].valid) begin
                mergedValid = 1'b1;
                mergedData  = rspList[i].data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= mergedValid;
        end
    end

    always_ff @(posedge clk) begin
        readData <= mergedData;
    end

endmodule

// File: socAddressDecode.sv
`timescale 1ns/100ps

module socAddressDecode import socPkg::*; #(
    parameter int ramWords = 4096
) (
    input   busReqT         busReq,
    output  periphReqT      ramReq,
    output  periphReqT      timerReq,
    output  periphReqT      randomReq,
    output  periphReqT      irqReq,
    output  logic           badRead
);

    regionT         region;
    logic           ramInRange;

    // copy payload, pass strobes only on a hit
    function automatic periphReqT gateReq(input busReqT req, input logic hit);
        periphReqT gated;
        gated.read      = req.read & hit;
        gated.write     = req.write & hit;
        gated.bwe       = req.bwe;
        gated.offset    = req.address[13:2];
        gated.writeData = req.writeData;
        return gated;
    endfunction

    // region from address bits 19 to 16
    always_comb begin
        case (busReq.address[19:16])
            regionRam:      region = selRam;
            regionTimer:    region = selTimer;
            regionRandom:   region = selRandom;
            regionIrq:      region = selIrq;
            default:        region = selUnmapped;
        endcase
    end

    // ram may be smaller than the 4k word window
    assign ramInRange = 32'(busReq.address[13:2]) < ramWords;

    // out of range ram accesses are dropped here
    assign ramReq    = gateReq(busReq, (region == selRam) && ramInRange);
    assign timerReq  = gateReq(busReq, region == selTimer);
    assign randomReq = gateReq(busReq, region == selRandom);
    assign irqReq    = gateReq(busReq, region == selIrq);

    // nobody answers these, readReturn fakes a zero
    assign badRead = busReq.read &&
                     ((region == selUnmapped) || ((region == selRam) && !ramInRange));

endmodule

// File: socCore.sv
`timescale 1ns/100ps

module socCore import socPkg::*; #(
    parameter int ramWords = 4096
) (
    input   logic           clk,
    input   logic           rstN,
    input   busReqT         busReq,
    output  logic           readValid,
    output  logic  [31:0]   readData,
    output  logic           interruptRequest
);

    // decode to execute
    periphReqT              ramReq;
    periphReqT              timerReq;
    periphReqT              randomReq;
    periphReqT              irqReq;
    logic                   badRead;

    // execute to result
    periphRspT              ramRsp;
    periphRspT              timerRsp;
    periphRspT              randomRsp;
    periphRspT              irqRsp;

    // timer expiry into the interrupt controller
    logic  [numTimers-1:0]  timerIrq;

    socAddressDecode #(.ramWords(ramWords))
    socAddressDecode_i(
        .busReq,
        .ramReq,
        .timerReq,
        .randomReq,
        .irqReq,
        .badRead
    );

    ramBank #(.ramWords(ramWords))
    ramBank_i(
        .clk,
        .rstN,
        .req                    (ramReq),
        .rsp                    (ramRsp)
    );

    timerBlock
    timerBlock_i(
        .clk,
        .rstN,
        .req                    (timerReq),
        .rsp                    (timerRsp),
        .timerIrq
    );

    randomSource
    randomSource_i(
        .clk,
        .rstN,
        .req                    (randomReq),
        .rsp                    (randomRsp)
    );

    interruptController
    interruptController_i(
        .clk,
        .rstN,
        .req                    (irqReq),
        .timerIrq,
        .rsp                    (irqRsp),
        .interruptRequest
    );

    readReturn
    readReturn_i(
        .clk,
        .rstN,
        .ramRsp,
        .timerRsp,
        .randomRsp,
        .irqRsp,
        .badRead,
        .readValid,
        .readData
    );

endmodule

// File: socCoreTb.sv
`timescale 1ns/100ps

module socCoreTb import socPkg::*; ();

    localparam int          ramWords     = 1024;
    localparam int          clkPeriod    = 8;
    localparam int          resetCycles  = 10;
    localparam logic [31:0] timerPeriod  = 32'd5;
    // reset, random, ram, bad address, reseed and timer tests
    localparam int          testCycles   = resetCycles + 5 + 30 + 15 + 20 + 45;
    localparam int          marginCycles = 100;

    // one read waiting for its return slot
    typedef struct packed {
        logic  [31:0]   value;
        int             issue;
        logic           atMost;
        logic  [2:0]    testId;
    } expectT;

    logic           clk;
    logic           rstN;
    busReqT         busReq;
    logic           readValid;
    logic  [31:0]   readData;
    logic           interruptRequest;

    int             cycleCount = 0;
    int             valueErrors;
    int             protocolErrors;
    expectT         expectQ [$];
    string          testNames [6] = '{"reset", "ram", "bad address", "random", "timer", "irq"};
    logic  [2:0]    testId;
    logic  [31:0]   stimState;

    // reference model
    logic  [31:0]           ramModel [ramWords];
    logic  [31:0]           periodModel [numTimers];
    logic  [31:0]           randomModel;
    logic  [irqLines-1:0]   maskModel;
    logic  [irqLines-1:0]   pendingModel;

    socCore #(.ramWords(ramWords))
    socCore_i(
        .clk,
        .rstN,
        .busReq,
        .readValid,
        .readData,
        .interruptRequest
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;

    // xorshift32 with shifts 13 17 5
    function automatic logic [31:0] xorshiftStep(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // stimulus stream
    function automatic logic [31:0] nextRand();
        stimState = xorshiftStep(stimState);
        return stimState;
    endfunction

    function automatic logic [31:0] makeAddress(input logic [3:0] region,
                                                input logic [11:0] offset);
        return {12'h0, region, 2'b00, offset, 2'b00};
    endfunction

    // ram beyond ramWords counts as unmapped
    function automatic regionT classify(input logic [31:0] address);
        case (address[19:16])
            regionRam:    return (32'(address[13:2]) < ramWords) ? selRam : selUnmapped;
            regionTimer:  return selTimer;
            regionRandom: return selRandom;
            regionIrq:    return selIrq;
            default:      return selUnmapped;
        endcase
    endfunction

    function automatic void modelWrite(input logic [31:0] address, input logic [31:0] data,
                                       input logic [3:0] bwe);
        logic [11:0] offset;
        offset = address[13:2];
        case (classify(address))
            selRam: begin
                for (int b = 0; b < 4; b++) begin
                    if (bwe[b]) begin
                        ramModel[offset][8*b +: 8] = data[8*b +: 8];
                    end
                end
            end
            selTimer: begin
                if (offset < numTimers) begin
                    periodModel[offset] = data;
                end
            end
            // zero seed falls back to the default
            selRandom: randomModel = (data == '0) ? randomSeedDefault : data;
            selIrq: begin
                if (offset == irqMaskOffset) begin
                    maskModel = data[irqLines-1:0];
                end else if (offset == irqClearOffset) begin
                    pendingModel = pendingModel & ~data[irqLines-1:0];
                end
            end
            default: ;
        endcase
    endfunction

    // expected read data
    // timer reads give only an upper bound on the count
    function automatic logic [31:0] modelRead(input logic [31:0] address);
        logic [11:0] offset;
        logic [31:0] value;
        offset = address[13:2];
        value  = '0;
        case (classify(address))
            selRam: value = ramModel[offset];
            selTimer: begin
                if (offset < numTimers) begin
                    value = periodModel[offset];
                end
            end
            selRandom: begin
                value       = randomModel;
                randomModel = xorshiftStep(randomModel);
            end
            selIrq: begin
                if (offset == irqMaskOffset) begin
                    value = 32'(maskModel);
                end else if (offset == irqClearOffset) begin
                    value = 32'(pendingModel);
                end
            end
            default: value = '0;
        endcase
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            valueErrors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic writeBus(input logic [31:0] address, input logic [31:0] data,
                            input logic [3:0] bwe);
        @(negedge clk);
        busReq = '{read: 1'b0, write: 1'b1, bwe: bwe, address: address, writeData: data};
        modelWrite(address, data, bwe);
    endtask

    task automatic readBus(input logic [31:0] address, input logic atMost);
        expectT entry;
        @(negedge clk);
        busReq = '{read: 1'b1, write: 1'b0, bwe: 4'h0, address: address, writeData: '0};
        // strobe cycle began at the last rising edge
        entry = '{value: modelRead(address), issue: cycleCount,
                  atMost: atMost, testId: testId};
        expectQ.push_back(entry);
    endtask

    task automatic idleBus(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            busReq = '0;
        end
    endtask

    // return cycle starts two edges after the strobe cycle
    // sampled mid-cycle on the falling edge
    always @(negedge clk) begin
        expectT head;
        if (rstN) begin
            if (expectQ.size() != 0 && expectQ[0].issue + 2 == cycleCount) begin
                head = expectQ.pop_front();
                assert (readValid === 1'b1) else begin
                    protocolErrors++;
                    $display("no readValid for the %s read issued at cycle %0d",
                             testNames[head.testId], head.issue);
                end
                if (readValid === 1'b1 && head.atMost) begin
                    assert (readData <= head.value) else begin
                        valueErrors++;
                        $display("CHECK FAILED %s expected at most %h actual %h",
                                 testNames[head.testId], head.value, readData);
                    end
                end else if (readValid === 1'b1) begin
                    checkValue(testNames[head.testId], head.value, readData);
                end
            end else begin
                assert (readValid === 1'b0) else begin
                    protocolErrors++;
                    $display("readValid at cycle %0d with no read due", cycleCount);
                end
            end
        end
    end

    initial begin
        logic [11:0] offsets [8];
        logic [31:0] bits;
        logic [31:0] seed;
        rstN           = 1'b0;
        busReq         = '0;
        valueErrors    = 0;
        protocolErrors = 0;
        testId         = 3'd0;
        stimState      = 32'hb32d;
        randomModel    = randomSeedDefault;
        maskModel      = '0;
        pendingModel   = '0;
        for (int t = 0; t < numTimers; t++) begin
            periodModel[t] = '0;
        end
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        // outputs quiet after reset and the first random value is the seed
        @(negedge clk);
        checkValue("reset readValid", 32'h0, 32'(readValid));
        checkValue("reset interruptRequest", 32'h0, 32'(interruptRequest));
        readBus(makeAddress(regionRandom, 12'h0), 1'b0);
        idleBus(4);

        // full writes first so partial writes never merge into unknown bytes
        testId = 3'd1;
        for (int i = 0; i < 8; i++) begin
            offsets[i] = 12'(nextRand() % ramWords);
            writeBus(makeAddress(regionRam, offsets[i]), nextRand(), 4'hf);
        end
        for (int i = 0; i < 8; i++) begin
            bits = nextRand();
            writeBus(makeAddress(regionRam, offsets[i]), nextRand(), bits[3:0]);
        end
        // back to back reads
        for (int i = 0; i < 8; i++) begin
            readBus(makeAddress(regionRam, offsets[i]), 1'b0);
        end
        idleBus(4);

        // regions 4 to 15 and ram beyond ramWords
        testId = 3'd2;
        for (int i = 0; i < 3; i++) begin
            bits = nextRand();
            readBus(makeAddress(4'(4 + bits % 12), bits[27:16]), 1'b0);
            readBus(makeAddress(regionRam, 12'(ramWords + bits[31:20] % (4096 - ramWords))),
                    1'b0);
        end
        // both aliases of a written word are dropped
        writeBus(makeAddress(regionRam, offsets[0] + 12'(ramWords)), nextRand(), 4'hf);
        writeBus(makeAddress(4'd7, offsets[0]), nextRand(), 4'hf);
        readBus(makeAddress(regionRam, offsets[0]), 1'b0);
        idleBus(4);

        // reseed and then a zero seed restarts from the default
        testId = 3'd3;
        seed   = nextRand() | 32'h1;
        writeBus(makeAddress(regionRandom, 12'h0), seed, 4'hf);
        repeat (8) readBus(makeAddress(regionRandom, 12'h0), 1'b0);
        writeBus(makeAddress(regionRandom, 12'h0), 32'h0, 4'hf);
        repeat (2) readBus(makeAddress(regionRandom, 12'h0), 1'b0);
        idleBus(4);

        // timer 1 onto irq line 1
        testId = 3'd4;
        writeBus(makeAddress(regionIrq, irqMaskOffset), 32'h2, 4'hf);
        writeBus(makeAddress(regionTimer, 12'd1), timerPeriod, 4'hf);
        idleBus(3 * timerPeriod);
        // expired at least once by now
        pendingModel[1] = 1'b1;
        readBus(makeAddress(regionIrq, irqClearOffset), 1'b0);
        readBus(makeAddress(regionTimer, 12'd1), 1'b1);
        idleBus(1);
        checkValue("interruptRequest set", 32'h1, 32'(interruptRequest));
        writeBus(makeAddress(regionTimer, timerStopBase + 12'd1), 32'h0, 4'hf);
        // let a pulse in flight land before the clear
        idleBus(2 * timerPeriod);

        testId = 3'd5;
        writeBus(makeAddress(regionIrq, irqClearOffset), 32'h2, 4'hf);
        idleBus(3);
        checkValue("interruptRequest cleared", 32'h0, 32'(interruptRequest));
        readBus(makeAddress(regionIrq, irqClearOffset), 1'b0);
        idleBus(4);

        while (expectQ.size() != 0) @(negedge clk);
        idleBus(2);
        $display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((testCycles + marginCycles) * clkPeriod);
        $display("watchdog expired at cycle %0d, the test did not finish", cycleCount);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: socPkg.sv
package socPkg;

    // master side request, one strobe per cycle
    typedef struct packed {
        logic           read;
        logic           write;
        logic  [3:0]    bwe;
        // byte address
        logic  [31:0]   address;
        logic  [31:0]   writeData;
    } busReqT;

    // per target request after decode
    typedef struct packed {
        logic           read;
        logic           write;
        logic  [3:0]    bwe;
        // word offset inside the target region
        logic  [11:0]   offset;
        logic  [31:0]   writeData;
    } periphReqT;

    // target read response, valid one cycle after the strobe
    typedef struct packed {
        logic           valid;
        logic  [31:0]   data;
    } periphRspT;

    // decoded target of the current strobe
    typedef enum logic [2:0] {
        selRam,
        selTimer,
        selRandom,
        selIrq,
        selUnmapped
    } regionT;

    // address map, compared against address[19:16]
    localparam logic [3:0]  regionRam         = 4'd0;
    localparam logic [3:0]  regionTimer       = 4'd1;
    localparam logic [3:0]  regionRandom      = 4'd2;
    localparam logic [3:0]  regionIrq         = 4'd3;

    // timer bank size
    localparam int          numTimers         = 3;

    // width of pending and mask
    localparam int          irqLines          = 16;

    // xorshift must never hold zero
    localparam logic [31:0] randomSeedDefault = 32'h1;

    // timer registers: offset t loads timer t, stop base plus t halts it
    localparam logic [11:0] timerStopBase     = 12'd4;

    // interrupt controller registers
    localparam logic [11:0] irqMaskOffset     = 12'd0;
    localparam logic [11:0] irqClearOffset    = 12'd1;

endpackage

// File: timerBlock.sv
`timescale 1ns/100ps

module timerBlock import socPkg::*; (
    input   logic                   clk,
    input   logic                   rstN,
    input   periphReqT              req,
    output  periphRspT              rsp,
    output  logic [numTimers-1:0]   timerIrq
);

    logic  [31:0]           period [numTimers];
    logic  [31:0]           count [numTimers];
    logic  [numTimers-1:0]  running;
    logic  [31:0]           readData;
    logic                   readValid;

    // reload value, only read while running
    always_ff @(posedge clk) begin
        for (int t = 0; t < numTimers; t++) begin
            if (req.write && (req.offset == 12'(t))) begin
                period[t] <= req.writeData;
            end
        end
    end

    // down-counters, expire on one and reload
    always_ff @(posedge clk) begin
        if (!rstN) begin
            running  <= '0;
            timerIrq <= '0;
            for (int t = 0; t < numTimers; t++) begin
                count[t] <= '0;
            end
        end else begin
            for (int t = 0; t < numTimers; t++) begin
                timerIrq[t] <= 1'b0;
                if (running[t]) begin
                    // period zero behaves like one
                    if (count[t] <= 32'd1) begin
                        count[t]    <= period[t];
                        timerIrq[t] <= 1'b1;
                    end else begin
                        count[t] <= count[t] - 32'd1;
                    end
                end
                // a new period restarts the count
                if (req.write && (req.offset == 12'(t))) begin
                    count[t]   <= req.writeData;
                    running[t] <= 1'b1;
                end
                if (req.write && (req.offset == timerStopBase + 12'(t))) begin
                    running[t] <= 1'b0;
                end
            end
        end
    end

    // live count readback, other offsets read zero
    always_ff @(posedge clk) begin
        if (req.read) begin
            readData <= '0;
            for (int t = 0; t < numTimers; t++) begin
                if (req.offset == 12'(t)) begin
                    readData <= count[t];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end

    assign rsp = '{valid: readValid, data: readData};

endmodule
